//--- dv/tb_stim.svh
`ifndef TB_STIM_SVH
`define TB_STIM_SVH

localparam int N_RANDOM = 40;
localparam int N_STEPS  = 26 + N_RANDOM;    // directed steps plus the random mix

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

function automatic instr_t enc_r(input logic f7b, input reg_addr_t rs2, input reg_addr_t rs1,
                                 input logic [2:0] f3, input reg_addr_t rd);
    return {1'b0, f7b, 5'b00000, rs2, rs1, f3, rd, OPC_REG};
endfunction

function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                 input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_IMM};
endfunction

function automatic instr_t enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                 input reg_addr_t rd);
    return {imm, rd, opc};
endfunction

function automatic instr_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                 input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

task automatic run_sequence();
    instr_t ins;
    logic [2:0] kind;
    rf_tag[5] = 4'd3;   // x5 done in the rob
    rob_rdy[3] = 1'b1;
    rf_tag[6] = 4'd7;   // x6 still pending
    // alu path with back-to-back dependences
    step(enc_i(12'hffb, 5'd2, 3'd0, 5'd1), 0, 0, 4'd1, 0, 0, 0);
    step(enc_r(1'b0, 5'd2, 5'd1, 3'd0, 5'd3), 0, 0, 4'd2, 0, 0, 0);
    step(enc_r(1'b1, 5'd6, 5'd5, 3'd0, 5'd4), 0, 0, 4'd4, 0, 0, 0);
    step(enc_i(12'h403, 5'd4, 3'd5, 5'd7), 0, 0, 4'd5, 0, 0, 0);
    step(enc_r(1'b1, 5'd7, 5'd3, 3'd5, 5'd8), 0, 0, 4'd6, 0, 0, 0);
    step(enc_r(1'b0, 5'd1, 5'd2, 3'd4, 5'd9), 0, 0, 4'd8, 0, 0, 0);
    step(enc_u(OPC_LUI, 20'habcde, 5'd10), 0, 0, 4'd9, 0, 0, 0);
    step(enc_u(OPC_AUIPC, 20'h00012, 5'd11), 0, 0, 4'd10, 0, 0, 0);
    step(enc_i(12'h003, 5'd11, 3'd1, 5'd12), 0, 0, 4'd11, 0, 0, 0);
    // compare station
    step(enc_r(1'b0, 5'd6, 5'd5, 3'd2, 5'd13), 0, 0, 4'd12, 0, 0, 0);
    step(enc_i(12'h007, 5'd13, 3'd3, 5'd14), 0, 0, 4'd13, 0, 0, 0);
    step(enc_b(13'h1ff0, 5'd6, 5'd5, 3'd0), 0, 0, 4'd14, 0, 0, 0);
    step(enc_b(13'h0024, 5'd14, 5'd1, 3'd4), 0, 0, 4'd15, 0, 0, 0);
    // the head is held under back-pressure
    ins = enc_r(1'b0, 5'd3, 5'd4, 3'd6, 5'd15);
    step(ins, 0, 0, 4'd1, 0, 1, 0);
    step(ins, 0, 0, 4'd1, 1, 0, 0);
    step(ins, 0, 0, 4'd0, 0, 0, 0);
    step(ins, 0, 0, 4'd1, 0, 0, 0);
    ins = enc_b(13'h0008, 5'd15, 5'd2, 3'd1);
    step(ins, 0, 0, 4'd2, 0, 0, 1);
    step(ins, 0, 0, 4'd2, 0, 0, 0);
    // dropped opcodes, x0 writes, empty queue
    step(32'h0000_2083, 0, 0, 4'd3, 0, 1, 1);
    step(32'h0080_00ef, 0, 0, 4'd3, 0, 0, 0);
    step(enc_i(12'h001, 5'd1, 3'd0, 5'd0), 0, 0, 4'd3, 0, 1, 0);
    step(enc_r(1'b0, 5'd1, 5'd1, 3'd0, 5'd16), 1, 0, 4'd3, 0, 0, 0);
    // flush drops the bypass
    step(enc_i(12'h010, 5'd1, 3'd0, 5'd17), 0, 0, 4'd4, 0, 0, 0);
    ins = enc_r(1'b0, 5'd17, 5'd17, 3'd0, 5'd18);
    step(ins, 0, 1, 4'd5, 0, 0, 0);
    step(ins, 0, 0, 4'd5, 0, 0, 0);
    // random mix over a few registers
    for (int i = 0; i < N_RANDOM; i++) begin
        kind = 3'(next_bits(3));
        case (kind)
            3'd0: ins = enc_r(next_bits(1) != 0, 5'(next_bits(3)), 5'(next_bits(3)), 3'd0,
                              5'(next_bits(3)));
            3'd1: ins = enc_i(12'(next_bits(12)), 5'(next_bits(3)), 3'd0, 5'(next_bits(3)));
            3'd2: ins = enc_r(1'b0, 5'(next_bits(3)), 5'(next_bits(3)), 3'(2 + next_bits(1)),
                              5'(next_bits(3)));
            3'd3: ins = enc_b(13'(next_bits(12) << 1), 5'(next_bits(3)), 5'(next_bits(3)),
                              3'(next_bits(3)));
            3'd4: ins = enc_i({1'b0, 1'(next_bits(1)), 5'd0, 5'(next_bits(5))},
                              5'(next_bits(3)), 3'd5, 5'(next_bits(3)));
            3'd5: ins = enc_u(OPC_LUI, 20'(next_bits(20)), 5'(next_bits(3)));
            3'd6: ins = enc_r(1'b0, 5'(next_bits(3)), 5'(next_bits(3)), 3'd7, 5'(next_bits(3)));
            default: ins = 32'h0000_2003 | (32'(next_bits(3)) << 7);
        endcase
        step(ins, next_bits(3) == 0, next_bits(4) == 0, 4'(next_bits(4)),
             next_bits(3) == 0, next_bits(3) == 0, next_bits(3) == 0);
    end
endtask

`endif

//--- dv/tb_decode_issue.sv
`timescale 1ns/1ps

module tb_decode_issue
    import issue_pkg::*;
;

    localparam int TAG_W = 4;

    logic             clk;
    logic             arst_n_i;
    logic             flush_i;
    instr_t           iq_instr_i;
    word_t            iq_pc_i;
    logic             iq_empty_i;
    logic             iq_read_o;
    reg_addr_t        rs1_addr_o;
    reg_addr_t        rs2_addr_o;
    word_t            rf_v1_i;
    logic [TAG_W-1:0] rf_q1_i;
    word_t            rf_v2_i;
    logic [TAG_W-1:0] rf_q2_i;
    logic             rename_we_o;
    reg_addr_t        rename_rd_o;
    logic [TAG_W-1:0] rename_tag_o;
    logic [TAG_W-1:0] rob_free_tag_i;
    logic             rob_full_i;
    word_t            rob_v1_i;
    logic             rob_rdy1_i;
    word_t            rob_v2_i;
    logic             rob_rdy2_i;
    logic             rob_write_o;
    word_t            rob_pc_o;
    reg_addr_t        rob_rd_o;
    logic             alu_full_i;
    logic             cmp_full_i;
    logic             alu_valid_o;
    alu_op_t          alu_op_o;
    word_t            alu_v1_o;
    logic [TAG_W-1:0] alu_q1_o;
    word_t            alu_v2_o;
    logic [TAG_W-1:0] alu_q2_o;
    logic [TAG_W-1:0] alu_tag_o;
    logic             cmp_valid_o;
    logic             cmp_br_o;
    cmp_op_t          cmp_op_o;
    word_t            cmp_v1_o;
    logic [TAG_W-1:0] cmp_q1_o;
    word_t            cmp_v2_o;
    logic [TAG_W-1:0] cmp_q2_o;
    word_t            cmp_pc_o;
    word_t            cmp_imm_o;
    logic [TAG_W-1:0] cmp_tag_o;

    // register file and reorder buffer models
    word_t            rf_val  [32];
    logic [TAG_W-1:0] rf_tag  [32];
    word_t            rob_val [16];
    logic             rob_rdy [16];
    logic             pend_we;      // rename seen at the last edge and applied at the next
    reg_addr_t        pend_rd;
    logic [TAG_W-1:0] pend_tag;
    logic             last_vld;
    reg_addr_t        last_rd;
    logic [TAG_W-1:0] last_tag;
    word_t            pc;
    logic [31:0]      lfsr;
    int               cycles;

    assign rf_v1_i    = rf_val[rs1_addr_o];
    assign rf_q1_i    = rf_tag[rs1_addr_o];
    assign rf_v2_i    = rf_val[rs2_addr_o];
    assign rf_q2_i    = rf_tag[rs2_addr_o];
    assign rob_v1_i   = rob_val[rf_q1_i];
    assign rob_rdy1_i = rob_rdy[rf_q1_i];
    assign rob_v2_i   = rob_val[rf_q2_i];
    assign rob_rdy2_i = rob_rdy[rf_q2_i];

    decode_issue #(.TAG_W(TAG_W)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_stop(input string why);
        $display("** FAIL **");
        $fatal(1, why);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            fail_stop("value mismatch");
        end
    endtask

    `include "tb_stim.svh"

    localparam int CYCLE_LIMIT = 4 * N_STEPS;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            fail_stop("timeout");
        end
    end

    // operand rule as the station should see it
    task automatic resolve(input reg_addr_t s, output word_t v, output logic [TAG_W-1:0] q);
        if (s != 0 && last_vld && s == last_rd) begin
            v = '0;
            q = last_tag;
        end else if (rf_tag[s] != 0 && rob_rdy[rf_tag[s]]) begin
            v = rob_val[rf_tag[s]];
            q = '0;
        end else begin
            v = rf_val[s];
            q = rf_tag[s];
        end
    endtask

    task automatic step(input instr_t ins, input logic empty, input logic fl,
                        input logic [TAG_W-1:0] tag, input logic rfull,
                        input logic afull, input logic cfull);
        logic [6:0]       opc;
        logic [2:0]       f3;
        reg_addr_t        rd;
        instr_class_t     cls;
        logic             wr;
        logic             s2imm;
        logic             alt;
        logic             ok;
        logic             disc;
        logic             full;
        logic             acc;
        word_t            imm;
        word_t            v1;
        word_t            v2;
        logic [TAG_W-1:0] q1;
        logic [TAG_W-1:0] q2;
        alu_op_t          op;
        opc   = ins[6:0];
        f3    = ins[14:12];
        rd    = ins[11:7];
        cls   = CLS_DROP;
        wr    = 1'b0;
        s2imm = 1'b0;
        alt   = 1'b0;
        imm   = '0;
        case (opc)
            OPC_LUI, OPC_AUIPC: begin
                cls   = CLS_ALU;
                wr    = 1'b1;
                s2imm = 1'b1;
                imm   = {ins[31:12], 12'h000};
            end
            OPC_IMM: begin
                cls   = (f3 == 3'd2 || f3 == 3'd3) ? CLS_CMP : CLS_ALU;
                wr    = 1'b1;
                s2imm = 1'b1;
                imm   = {{20{ins[31]}}, ins[31:20]};
                alt   = ins[30] && f3 == 3'd5;
            end
            OPC_REG: begin
                cls = (f3 == 3'd2 || f3 == 3'd3) ? CLS_CMP : CLS_ALU;
                wr  = 1'b1;
                alt = ins[30] && (f3 == 3'd0 || f3 == 3'd5);
            end
            OPC_BRANCH: begin
                cls = CLS_BRANCH;
                imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: ;
        endcase
        iq_instr_i     = ins;
        iq_pc_i        = pc;
        iq_empty_i     = empty;
        flush_i        = fl;
        rob_free_tag_i = tag;
        rob_full_i     = rfull;
        alu_full_i     = afull;
        cmp_full_i     = cfull;
        #10;
        resolve(ins[19:15], v1, q1);
        resolve(ins[24:20], v2, q2);
        op = {alt, f3};
        if (s2imm) begin
            v2 = imm;
            q2 = '0;
        end
        if (opc == OPC_LUI || opc == OPC_AUIPC) begin
            op = ALU_ADD;
            v1 = (opc == OPC_AUIPC) ? pc : '0;
            q1 = '0;
        end
        ok   = !empty && !fl;
        disc = ok && (cls == CLS_DROP || (wr && rd == 0));
        full = (cls == CLS_ALU) ? afull : cfull;
        acc  = ok && !disc && !rfull && tag != 0 && !full;
        check("rs1_addr_o", 32'(ins[19:15]), 32'(rs1_addr_o));
        check("rs2_addr_o", 32'(ins[24:20]), 32'(rs2_addr_o));
        check("iq_read_o", 32'(acc || disc), 32'(iq_read_o));
        check("rename_we_o", 32'(acc && wr), 32'(rename_we_o));
        if (acc && wr) begin
            check("rename_rd_o", 32'(rd), 32'(rename_rd_o));
            check("rename_tag_o", 32'(tag), 32'(rename_tag_o));
        end
        @(negedge clk);
        check("alu_valid_o", 32'(acc && cls == CLS_ALU), 32'(alu_valid_o));
        check("cmp_valid_o", 32'(acc && cls != CLS_ALU), 32'(cmp_valid_o));
        check("rob_write_o", 32'(acc), 32'(rob_write_o));
        if (acc && cls == CLS_ALU) begin
            check("alu_op_o", 32'(op), 32'(alu_op_o));
            check("alu_v1_o", v1, alu_v1_o);
            check("alu_q1_o", 32'(q1), 32'(alu_q1_o));
            check("alu_v2_o", v2, alu_v2_o);
            check("alu_q2_o", 32'(q2), 32'(alu_q2_o));
            check("alu_tag_o", 32'(tag), 32'(alu_tag_o));
        end
        if (acc && cls != CLS_ALU) begin
            check("cmp_br_o", 32'(cls == CLS_BRANCH), 32'(cmp_br_o));
            check("cmp_op_o", 32'(f3), 32'(cmp_op_o));
            check("cmp_v1_o", v1, cmp_v1_o);
            check("cmp_q1_o", 32'(q1), 32'(cmp_q1_o));
            check("cmp_v2_o", v2, cmp_v2_o);
            check("cmp_q2_o", 32'(q2), 32'(cmp_q2_o));
            check("cmp_pc_o", (cls == CLS_BRANCH) ? pc : 32'h0, cmp_pc_o);
            check("cmp_imm_o", (cls == CLS_BRANCH) ? imm : 32'h0, cmp_imm_o);
            check("cmp_tag_o", 32'(tag), 32'(cmp_tag_o));
        end
        if (acc) begin
            check("rob_pc_o", pc, rob_pc_o);
            check("rob_rd_o", (cls == CLS_BRANCH) ? 32'h0 : 32'(rd), 32'(rob_rd_o));
        end
        if (pend_we) begin
            rf_tag[pend_rd]   = pend_tag;
            rob_rdy[pend_tag] = next_bits(1) != 0;  // producer may already be done
            rob_val[pend_tag] = next_bits(32);
        end
        pend_we  = acc && wr;
        pend_rd  = rd;
        pend_tag = tag;
        last_vld = acc && wr;
        last_rd  = rd;
        last_tag = tag;
        if (acc || disc) pc = pc + 4;
    endtask

    initial begin
        arst_n_i       = 1'b0;
        flush_i        = 1'b0;
        iq_instr_i     = '0;
        iq_pc_i        = '0;
        iq_empty_i     = 1'b1;
        rob_free_tag_i = '0;
        rob_full_i     = 1'b0;
        alu_full_i     = 1'b0;
        cmp_full_i     = 1'b0;
        cycles         = 0;
        lfsr           = 32'h3f92c65b;
        pend_we        = 1'b0;
        pend_rd        = '0;
        pend_tag       = '0;
        last_vld       = 1'b0;
        last_rd        = '0;
        last_tag       = '0;
        pc             = 32'h0000_1000;
        for (int r = 0; r < 32; r++) begin
            rf_val[r] = (r == 0) ? '0 : next_bits(32);
            rf_tag[r] = '0;
        end
        for (int t = 0; t < 16; t++) begin
            rob_val[t] = next_bits(32);
            rob_rdy[t] = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        #10;
        check("iq_read_o", 0, 32'(iq_read_o));
        check("alu_valid_o", 0, 32'(alu_valid_o));
        check("cmp_valid_o", 0, 32'(cmp_valid_o));
        check("rob_write_o", 0, 32'(rob_write_o));
        check("rename_we_o", 0, 32'(rename_we_o));
        @(negedge clk);
        run_sequence();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- flist.f
src/issue_pkg.sv
src/instr_fields.sv
src/operand_resolve.sv
src/dispatch_ctrl.sv
src/issue_regs.sv
src/decode_issue.sv
+incdir+dv
dv/tb_decode_issue.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the decode/issue testbench with verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_decode_issue -f flist.f \
    --Mdir obj_dir -o sim_decode_issue > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_decode_issue > sim.log 2>&1
sim_status=$?

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0

//--- src/decode_issue.sv
`timescale 1ns/1ps

module decode_issue
    import issue_pkg::*;
#(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             flush_i,
    // instruction queue
    input  instr_t           iq_instr_i,
    input  word_t            iq_pc_i,
    input  logic             iq_empty_i,
    output logic             iq_read_o,
    // register file
    output reg_addr_t        rs1_addr_o,
    output reg_addr_t        rs2_addr_o,
    input  word_t            rf_v1_i,
    input  logic [TAG_W-1:0] rf_q1_i,
    input  word_t            rf_v2_i,
    input  logic [TAG_W-1:0] rf_q2_i,
    output logic             rename_we_o,
    output reg_addr_t        rename_rd_o,
    output logic [TAG_W-1:0] rename_tag_o,
    // reorder buffer
    input  logic [TAG_W-1:0] rob_free_tag_i,
    input  logic             rob_full_i,
    input  word_t            rob_v1_i,
    input  logic             rob_rdy1_i,
    input  word_t            rob_v2_i,
    input  logic             rob_rdy2_i,
    output logic             rob_write_o,
    output word_t            rob_pc_o,
    output reg_addr_t        rob_rd_o,
    // reservation stations
    input  logic             alu_full_i,
    input  logic             cmp_full_i,
    output logic             alu_valid_o,
    output alu_op_t          alu_op_o,
    output word_t            alu_v1_o,
    output logic [TAG_W-1:0] alu_q1_o,
    output word_t            alu_v2_o,
    output logic [TAG_W-1:0] alu_q2_o,
    output logic [TAG_W-1:0] alu_tag_o,
    output logic             cmp_valid_o,
    output logic             cmp_br_o,
    output cmp_op_t          cmp_op_o,
    output word_t            cmp_v1_o,
    output logic [TAG_W-1:0] cmp_q1_o,
    output word_t            cmp_v2_o,
    output logic [TAG_W-1:0] cmp_q2_o,
    output word_t            cmp_pc_o,
    output word_t            cmp_imm_o,
    output logic [TAG_W-1:0] cmp_tag_o
);

    reg_addr_t        rd;
    logic [2:0]       funct3;
    logic             alt;
    word_t            imm;
    instr_class_t     cls;
    logic             writes_rd;
    logic             src2_is_imm;
    logic             accept;
    word_t            src1_v;
    word_t            src2_v;
    logic [TAG_W-1:0] src1_q;
    logic [TAG_W-1:0] src2_q;

    assign rename_rd_o  = rd;
    assign rename_tag_o = rob_free_tag_i;   // rf takes it one edge later

    instr_fields u_fields (
        .instr_i       (iq_instr_i),
        .rs1_o         (rs1_addr_o),
        .rs2_o         (rs2_addr_o),
        .rd_o          (rd),
        .funct3_o      (funct3),
        .alt_o         (alt),
        .imm_o         (imm),
        .class_o       (cls),
        .writes_rd_o   (writes_rd),
        .src2_is_imm_o (src2_is_imm)
    );

    operand_resolve #(.TAG_W(TAG_W)) u_operands (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .accept_i    (accept),
        .writes_rd_i (writes_rd),
        .rs1_i       (rs1_addr_o),
        .rs2_i       (rs2_addr_o),
        .rd_i        (rd),
        .free_tag_i  (rob_free_tag_i),
        .rf_q1_i     (rf_q1_i),
        .rf_q2_i     (rf_q2_i),
        .rf_v1_i     (rf_v1_i),
        .rf_v2_i     (rf_v2_i),
        .rob_v1_i    (rob_v1_i),
        .rob_v2_i    (rob_v2_i),
        .rob_rdy1_i  (rob_rdy1_i),
        .rob_rdy2_i  (rob_rdy2_i),
        .src1_v_o    (src1_v),
        .src2_v_o    (src2_v),
        .src1_q_o    (src1_q),
        .src2_q_o    (src2_q)
    );

    dispatch_ctrl #(.TAG_W(TAG_W)) u_ctrl (
        .iq_empty_i  (iq_empty_i),
        .flush_i     (flush_i),
        .rob_full_i  (rob_full_i),
        .free_tag_i  (rob_free_tag_i),
        .alu_full_i  (alu_full_i),
        .cmp_full_i  (cmp_full_i),
        .class_i     (cls),
        .writes_rd_i (writes_rd),
        .rd_i        (rd),
        .accept_o    (accept),
        .iq_read_o   (iq_read_o),
        .rename_we_o (rename_we_o)
    );

    issue_regs #(.TAG_W(TAG_W)) u_regs (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .accept_i      (accept),
        .class_i       (cls),
        .opcode_i      (iq_instr_i[6:0]),
        .funct3_i      (funct3),
        .alt_i         (alt),
        .src2_is_imm_i (src2_is_imm),
        .imm_i         (imm),
        .pc_i          (iq_pc_i),
        .rd_i          (rd),
        .free_tag_i    (rob_free_tag_i),
        .src1_v_i      (src1_v),
        .src1_q_i      (src1_q),
        .src2_v_i      (src2_v),
        .src2_q_i      (src2_q),
        .alu_valid_o   (alu_valid_o),
        .alu_op_o      (alu_op_o),
        .alu_v1_o      (alu_v1_o),
        .alu_q1_o      (alu_q1_o),
        .alu_v2_o      (alu_v2_o),
        .alu_q2_o      (alu_q2_o),
        .alu_tag_o     (alu_tag_o),
        .cmp_valid_o   (cmp_valid_o),
        .cmp_br_o      (cmp_br_o),
        .cmp_op_o      (cmp_op_o),
        .cmp_v1_o      (cmp_v1_o),
        .cmp_q1_o      (cmp_q1_o),
        .cmp_v2_o      (cmp_v2_o),
        .cmp_q2_o      (cmp_q2_o),
        .cmp_pc_o      (cmp_pc_o),
        .cmp_imm_o     (cmp_imm_o),
        .cmp_tag_o     (cmp_tag_o),
        .rob_write_o   (rob_write_o),
        .rob_pc_o      (rob_pc_o),
        .rob_rd_o      (rob_rd_o)
    );

endmodule

//--- src/dispatch_ctrl.sv
`timescale 1ns/1ps

module dispatch_ctrl
    import issue_pkg::*;
#(
    parameter int TAG_W = 4
) (
    input  logic             iq_empty_i,
    input  logic             flush_i,
    input  logic             rob_full_i,
    input  logic [TAG_W-1:0] free_tag_i,
    input  logic             alu_full_i,
    input  logic             cmp_full_i,
    input  instr_class_t     class_i,
    input  logic             writes_rd_i,
    input  reg_addr_t        rd_i,
    output logic             accept_o,
    output logic             iq_read_o,
    output logic             rename_we_o
);

    logic head_ok;
    logic is_drop;
    logic station_full;
    logic discard;
    logic rob_ok;

    // target station of the head
    always_comb begin
        is_drop      = 1'b0;
        station_full = 1'b0;
        case (class_i)
            CLS_ALU: begin
                station_full = alu_full_i;
            end
            CLS_CMP, CLS_BRANCH: begin
                station_full = cmp_full_i;
            end
            default: begin
                is_drop = 1'b1;    // unsupported, never issued
            end
        endcase
    end

    assign head_ok = !iq_empty_i && !flush_i;

    // result would go to x0, so nothing to do
    assign discard = head_ok && (is_drop || (writes_rd_i && rd_i == '0));

    // tag 0 is reserved for "ready"
    assign rob_ok = !rob_full_i && (free_tag_i != '0);

    assign accept_o    = head_ok && !discard && rob_ok && !station_full;
    assign iq_read_o   = accept_o || discard;
    assign rename_we_o = accept_o && writes_rd_i;

endmodule

//--- src/instr_fields.sv
`timescale 1ns/1ps

module instr_fields
    import issue_pkg::*;
(
    input  instr_t       instr_i,
    output reg_addr_t    rs1_o,
    output reg_addr_t    rs2_o,
    output reg_addr_t    rd_o,
    output logic [2:0]   funct3_o,
    output logic         alt_o,
    output word_t        imm_o,
    output instr_class_t class_o,
    output logic         writes_rd_o,
    output logic         src2_is_imm_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_cmp_f3;
    word_t      i_imm;
    word_t      b_imm;
    word_t      u_imm;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign rd_o      = instr_i[11:7];
    assign rs1_o     = instr_i[19:15];
    assign rs2_o     = instr_i[24:20];
    assign funct3_o  = funct3;
    assign is_cmp_f3 = (funct3 == F3_SLT) || (funct3 == F3_SLTU);

    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign b_imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'h000};

    always_comb begin
        imm_o         = '0;
        class_o       = CLS_DROP;   // loads, stores, jumps, system
        writes_rd_o   = 1'b0;
        src2_is_imm_o = 1'b0;
        alt_o         = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                imm_o         = u_imm;
                class_o       = CLS_ALU;
                writes_rd_o   = 1'b1;
                src2_is_imm_o = 1'b1;
            end
            OPC_IMM: begin
                imm_o         = i_imm;
                class_o       = is_cmp_f3 ? CLS_CMP : CLS_ALU;
                writes_rd_o   = 1'b1;
                src2_is_imm_o = 1'b1;
                alt_o         = instr_i[30] && (funct3 == F3_SR);  // srai only
            end
            OPC_REG: begin
                class_o     = is_cmp_f3 ? CLS_CMP : CLS_ALU;
                writes_rd_o = 1'b1;
                alt_o       = instr_i[30];
            end
            OPC_BRANCH: begin
                imm_o   = b_imm;
                class_o = CLS_BRANCH;
            end
            default: ;
        endcase
    end

endmodule

//--- src/issue_pkg.sv
package issue_pkg;

    typedef logic [31:0] word_t;       // values, pcs, immediates
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [3:0]  alu_op_t;     // {alt, funct3}
    typedef logic [2:0]  cmp_op_t;     // funct3
    typedef logic [2:0]  instr_class_t;

    // instruction classes
    localparam instr_class_t CLS_DROP   = 3'd0;
    localparam instr_class_t CLS_ALU    = 3'd1;
    localparam instr_class_t CLS_CMP    = 3'd2;
    localparam instr_class_t CLS_BRANCH = 3'd3;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 codes that decide routing
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SR   = 3'b101;

    localparam alu_op_t ALU_ADD = 4'b0000;
    localparam alu_op_t ALU_SUB = 4'b1000;
    localparam alu_op_t ALU_SRL = 4'b0101;
    localparam alu_op_t ALU_SRA = 4'b1101;

endpackage

//--- src/issue_regs.sv
`timescale 1ns/1ps

module issue_regs
    import issue_pkg::*;
#(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             flush_i,
    input  logic             accept_i,
    input  instr_class_t     class_i,
    input  logic [6:0]       opcode_i,
    input  logic [2:0]       funct3_i,
    input  logic             alt_i,
    input  logic             src2_is_imm_i,
    input  word_t            imm_i,
    input  word_t            pc_i,
    input  reg_addr_t        rd_i,
    input  logic [TAG_W-1:0] free_tag_i,
    input  word_t            src1_v_i,
    input  logic [TAG_W-1:0] src1_q_i,
    input  word_t            src2_v_i,
    input  logic [TAG_W-1:0] src2_q_i,
    output logic             alu_valid_o,
    output alu_op_t          alu_op_o,
    output word_t            alu_v1_o,
    output logic [TAG_W-1:0] alu_q1_o,
    output word_t            alu_v2_o,
    output logic [TAG_W-1:0] alu_q2_o,
    output logic [TAG_W-1:0] alu_tag_o,
    output logic             cmp_valid_o,
    output logic             cmp_br_o,
    output cmp_op_t          cmp_op_o,
    output word_t            cmp_v1_o,
    output logic [TAG_W-1:0] cmp_q1_o,
    output word_t            cmp_v2_o,
    output logic [TAG_W-1:0] cmp_q2_o,
    output word_t            cmp_pc_o,
    output word_t            cmp_imm_o,
    output logic [TAG_W-1:0] cmp_tag_o,
    output logic             rob_write_o,
    output word_t            rob_pc_o,
    output reg_addr_t        rob_rd_o
);

    logic             is_upper;
    logic             is_branch;
    logic             alu_sel;
    logic             cmp_sel;
    alu_op_t          reg_op;
    alu_op_t          op_n;
    word_t            v1_n;
    word_t            v2_n;
    logic [TAG_W-1:0] q1_n;
    logic [TAG_W-1:0] q2_n;

    assign is_upper  = (opcode_i == OPC_LUI) || (opcode_i == OPC_AUIPC);
    assign is_branch = (class_i == CLS_BRANCH);
    assign alu_sel   = accept_i && (class_i == CLS_ALU);
    assign cmp_sel   = accept_i && ((class_i == CLS_CMP) || is_branch);

    // alt only meaningful on add/sub and the right shifts
    always_comb begin
        case (funct3_i)
            ALU_ADD[2:0]: reg_op = alt_i ? ALU_SUB : ALU_ADD;
            F3_SR:        reg_op = alt_i ? ALU_SRA : ALU_SRL;
            default:      reg_op = {1'b0, funct3_i};
        endcase
    end

    always_comb begin
        op_n = reg_op;
        v1_n = src1_v_i;
        q1_n = src1_q_i;
        v2_n = src2_v_i;
        q2_n = src2_q_i;
        if (src2_is_imm_i) begin
            v2_n = imm_i;
            q2_n = '0;
        end
        if (is_upper) begin
            op_n = ALU_ADD;
            v1_n = (opcode_i == OPC_AUIPC) ? pc_i : '0;  // lui adds to zero
            q1_n = '0;
        end
    end

    // one-cycle pulses
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_valid_o <= 1'b0;
            cmp_valid_o <= 1'b0;
            rob_write_o <= 1'b0;
        end else begin
            alu_valid_o <= alu_sel && !flush_i;
            cmp_valid_o <= cmp_sel && !flush_i;
            rob_write_o <= accept_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_sel) begin
            alu_op_o  <= op_n;
            alu_v1_o  <= v1_n;
            alu_q1_o  <= q1_n;
            alu_v2_o  <= v2_n;
            alu_q2_o  <= q2_n;
            alu_tag_o <= free_tag_i;
        end
        if (cmp_sel) begin
            cmp_br_o  <= is_branch;
            cmp_op_o  <= funct3_i;
            cmp_v1_o  <= v1_n;
            cmp_q1_o  <= q1_n;
            cmp_v2_o  <= v2_n;
            cmp_q2_o  <= q2_n;
            cmp_pc_o  <= is_branch ? pc_i : '0;
            cmp_imm_o <= is_branch ? imm_i : '0;   // target offset
            cmp_tag_o <= free_tag_i;
        end
        if (accept_i) begin
            rob_pc_o <= pc_i;
            rob_rd_o <= is_branch ? '0 : rd_i;
        end
    end

endmodule

//--- src/operand_resolve.sv
`timescale 1ns/1ps

module operand_resolve
    import issue_pkg::*;
#(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             flush_i,
    input  logic             accept_i,
    input  logic             writes_rd_i,
    input  reg_addr_t        rs1_i,
    input  reg_addr_t        rs2_i,
    input  reg_addr_t        rd_i,
    input  logic [TAG_W-1:0] free_tag_i,
    input  logic [TAG_W-1:0] rf_q1_i,
    input  logic [TAG_W-1:0] rf_q2_i,
    input  word_t            rf_v1_i,
    input  word_t            rf_v2_i,
    input  word_t            rob_v1_i,
    input  word_t            rob_v2_i,
    input  logic             rob_rdy1_i,
    input  logic             rob_rdy2_i,
    output word_t            src1_v_o,
    output word_t            src2_v_o,
    output logic [TAG_W-1:0] src1_q_o,
    output logic [TAG_W-1:0] src2_q_o
);

    // destination issued on the previous edge, not yet visible in the rf
    logic             last_vld;
    reg_addr_t        last_rd;
    logic [TAG_W-1:0] last_tag;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_vld <= 1'b0;
            last_rd  <= '0;
            last_tag <= '0;
        end else if (accept_i && writes_rd_i && !flush_i) begin
            last_vld <= 1'b1;
            last_rd  <= rd_i;
            last_tag <= free_tag_i;
        end else begin
            last_vld <= 1'b0;
            last_rd  <= '0;
            last_tag <= '0;
        end
    end

    // returns {q, value}
    function automatic logic [TAG_W+31:0] pick(input reg_addr_t        src,
                                               input logic [TAG_W-1:0] rf_q,
                                               input word_t            rf_v,
                                               input word_t            rob_v,
                                               input logic             rob_rdy);
        logic [TAG_W+31:0] res;
        if (src != '0 && last_vld && src == last_rd) begin
            res = {last_tag, 32'd0};
        end else if (rf_q != '0 && rob_rdy) begin
            res = {{TAG_W{1'b0}}, rob_v};    // producer done, not committed
        end else begin
            res = {rf_q, rf_v};
        end
        return res;
    endfunction

    always_comb begin
        {src1_q_o, src1_v_o} = pick(rs1_i, rf_q1_i, rf_v1_i, rob_v1_i, rob_rdy1_i);
        {src2_q_o, src2_v_o} = pick(rs2_i, rf_q2_i, rf_v2_i, rob_v2_i, rob_rdy2_i);
    end

endmodule
